//--- hdl/tsRecPkg.sv
`default_nettype none

package tsRecPkg;

	//////////////////////////////////////////////////
	// Stream sample and recorder mode.

	typedef struct packed {
		logic       valid;                     // Word carries stream data.
		logic       sync;                      // Packet start marker.
		logic [7:0] data;                      // Stream byte.
	} tsWord_t;

	typedef enum logic [1:0] {
		modePass     = 2'd0,                   // Live input goes to output.
		modeRecord   = 2'd1,                   // Live output, stream stored to memory.
		modeReplay   = 2'd2,                   // Memory contents played out.
		modeStopping = 2'd3                    // Replay aborted, draining reads.
	} tsMode_t;

	//////////////////////////////////////////////////
	// External word memory.

	localparam int memAddrW = 8;               // Word address width.
	typedef logic [memAddrW-1:0] memAddr_t;

	localparam int memDataW = 32;              // Memory word width.
	typedef logic [memDataW-1:0] memData_t;

	localparam int wordPadW = 22;              // Zero bits under a stored sample.
	localparam int recWords = 64;              // Words per recording.

	//////////////////////////////////////////////////
	// Stream FIFOs.

	localparam int fifoDepth = 8;              // Entries per FIFO.
	typedef logic [$clog2(fifoDepth+1)-1:0] fifoCount_t;

endpackage

`default_nettype wire

//--- hdl/memWriteIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memWriteIf import tsRecPkg::*; ();

	memAddr_t address;                         // Word address of the write.
	logic     write;                           // Write request.
	memData_t writeData;                       // Data held with the request.
	logic     waitRequest;                     // Memory stalls the request.

	modport writer (
		output address, write, writeData,
		input  waitRequest
	);

	modport memory (
		input  address, write, writeData,
		output waitRequest
	);

endinterface

`default_nettype wire

//--- hdl/memReadIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memReadIf import tsRecPkg::*; ();

	memAddr_t address;                         // Word address of the read.
	logic     read;                            // Read request.
	logic     waitRequest;                     // Memory stalls the request.
	logic     readDataValid;                   // One returned word this cycle.
	memData_t readData;                        // Returned word, in request order.

	modport reader (
		output address, read,
		input  waitRequest, readDataValid, readData
	);

	modport memory (
		input  address, read,
		output waitRequest, readDataValid, readData
	);

endinterface

`default_nettype wire

//--- hdl/tsStreamFifo.sv
`timescale 1ns/1ps
`default_nettype none

module tsStreamFifo import tsRecPkg::*; (
	input  logic       SYS_CLOCK,             // System clock.
	input  logic       SYS_RESET,             // Asynchronous reset, active high.
	input  tsMode_t    mode,                  // Flushes itself in passthrough.
	input  tsWord_t    inWord,                // Push side word.
	input  logic       inValid,               // Push side valid.
	input  logic       outReady,              // Pop side ready.
	output logic       inReady,               // Room for one more word.
	output tsWord_t    outWord,               // Word at the head.
	output logic       outValid,              // Head word present.
	output fifoCount_t count                  // Current occupancy.
);

	tsWord_t                        mem [fifoDepth];
	logic [$clog2(fifoDepth)-1:0]   wrPtr;    // Next slot to fill.
	logic [$clog2(fifoDepth)-1:0]   rdPtr;    // Head slot.
	logic                           flush;
	logic                           push;
	logic                           pop;

	assign flush    = (mode == modePass);                      // Empty outside record and replay.
	assign inReady  = (count != fifoCount_t'(fifoDepth));     // Not full.
	assign outValid = (count != '0);                          // Not empty.
	assign outWord  = mem[rdPtr];
	assign push     = inValid && inReady;
	assign pop      = outValid && outReady;

	//////////////////////////////////////////////////
	// Pointers and occupancy.

	always_ff @(posedge SYS_CLOCK or posedge SYS_RESET) begin
		if (SYS_RESET) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (flush) begin
			wrPtr <= '0;                          // Drop everything held.
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;      // Wraps at the power of two depth.
			if (pop) rdPtr <= rdPtr + 1'b1;
			count <= count + fifoCount_t'(push) - fifoCount_t'(pop); // Push and pop may overlap.
		end
	end

	// Storage array.
	always_ff @(posedge SYS_CLOCK) begin
		if (push && !flush) begin
			mem[wrPtr] <= inWord;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tsModeControl.sv
`timescale 1ns/1ps
`default_nettype none

module tsModeControl import tsRecPkg::*; (
	input  logic    SYS_CLOCK,                // System clock.
	input  logic    SYS_RESET,                // Asynchronous reset, active high.
	input  logic    rec,                      // Start recording.
	input  logic    play,                     // Start replay.
	input  logic    pass,                     // Abort replay.
	input  logic    recordDone,               // Last write accepted this cycle.
	input  logic    readsDone,                // No reads outstanding, all returned.
	input  logic    replayPending,            // Replay FIFO still holds words.
	output tsMode_t mode                      // Current recorder mode.
);

	//////////////////////////////////////////////////
	// Mode register.

	always_ff @(posedge SYS_CLOCK or posedge SYS_RESET) begin
		if (SYS_RESET) begin
			mode <= modePass;
		end else begin
			case (mode)
				modePass: begin
					if (rec) begin
						mode <= modeRecord;        // Rec wins over play.
					end else if (play) begin
						mode <= modeReplay;
					end
				end
				modeRecord: begin
					if (recordDone) begin
						mode <= modePass;          // Recording length reached.
					end
				end
				modeReplay: begin
					if (pass) begin
						mode <= modeStopping;      // Early stop, drain reads first.
					end else if (readsDone && !replayPending) begin
						mode <= modePass;          // Everything played out.
					end
				end
				modeStopping: begin
					if (readsDone) begin
						mode <= modePass;          // Memory is quiet.
					end
				end
				default: mode <= modePass;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/tsPortStage.sv
`timescale 1ns/1ps
`default_nettype none

module tsPortStage import tsRecPkg::*; (
	input  logic       SYS_CLOCK,             // System clock.
	input  logic       SYS_RESET,             // Asynchronous reset, active high.
	input  tsMode_t    mode,                  // Current recorder mode.
	input  logic       tsValidIn,             // Stream valid in.
	input  logic       tsSyncIn,              // Stream sync in.
	input  logic [7:0] tsDataIn,              // Stream byte in.
	input  logic       recordReady,           // Record FIFO has room.
	input  tsWord_t    replayWord,            // Head of the replay FIFO.
	input  logic       replayValid,           // Replay FIFO not empty.
	input  logic       rec,                   // Rec pulse, clears the overflow flag.
	output logic       tsValidOut,            // Stream valid out.
	output logic       tsSyncOut,             // Stream sync out.
	output logic [7:0] tsDataOut,             // Stream byte out.
	output tsWord_t    recordWord,            // Word pushed for recording.
	output logic       recordValid,           // Push request.
	output logic       replayReady,           // Pop request.
	output logic       recOverflow            // Sticky lost word flag.
);

	tsWord_t capWord;                          // Capture register.
	tsWord_t outWord;                          // Output register.

	assign recordWord  = capWord;
	assign recordValid = capWord.valid && (mode == modeRecord);
	assign replayReady = (mode == modeReplay); // Pop whenever a word is there.
	assign tsValidOut  = outWord.valid;
	assign tsSyncOut   = outWord.sync;
	assign tsDataOut   = outWord.data;

	//////////////////////////////////////////////////
	// Capture, overflow and output selection.

	always_ff @(posedge SYS_CLOCK or posedge SYS_RESET) begin
		if (SYS_RESET) begin
			capWord     <= '0;
			outWord     <= '0;
			recOverflow <= 1'b0;
		end else begin
			capWord <= '{valid: tsValidIn, sync: tsSyncIn, data: tsDataIn};
			if (rec) begin
				recOverflow <= 1'b0;               // New recording, fresh flag.
			end else if (recordValid && !recordReady) begin
				recOverflow <= 1'b1;               // Word dropped on a full FIFO.
			end
			case (mode)
				modePass, modeRecord: outWord <= capWord; // Live stream, two cycle latency.
				modeReplay: outWord <= replayValid ? replayWord : '0; // Gap when empty.
				default: outWord <= '0;            // Nothing while stopping.
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/memWriter.sv
`timescale 1ns/1ps
`default_nettype none

module memWriter import tsRecPkg::*; (
	input  logic    SYS_CLOCK,                // System clock.
	input  logic    SYS_RESET,                // Asynchronous reset, active high.
	input  tsMode_t mode,                     // Current recorder mode.
	input  tsWord_t word,                     // Head of the record FIFO.
	input  logic    valid,                    // Record FIFO not empty.
	output logic    ready,                    // Pop request.
	output logic    recordDone,               // Last write accepted.
	memWriteIf.writer wr                      // Memory write channel.
);

	logic     pending;                         // Write waiting for acceptance.
	memAddr_t address;                         // Also the count of accepted writes.
	memData_t data;                            // Held write data.
	logic     accept;

	assign ready      = (mode == modeRecord) && !pending;
	assign accept     = pending && !wr.waitRequest;
	assign recordDone = accept && (address == memAddr_t'(recWords - 1));
	assign wr.address   = address;
	assign wr.write     = pending;
	assign wr.writeData = data;

	always_ff @(posedge SYS_CLOCK or posedge SYS_RESET) begin
		if (SYS_RESET) begin
			pending <= 1'b0;
			address <= '0;
		end else if (mode != modeRecord) begin
			pending <= 1'b0;
			address <= '0;                        // Each recording starts at zero.
		end else if (accept) begin
			pending <= 1'b0;
			address <= address + 1'b1;            // Next word slot.
		end else if (valid && ready) begin
			pending <= 1'b1;                      // Hold until accepted.
		end
	end

	// Sample sits on top, padding below.
	always_ff @(posedge SYS_CLOCK) begin
		if (valid && ready) begin
			data <= {word, {wordPadW{1'b0}}};
		end
	end

endmodule

`default_nettype wire

//--- hdl/memReader.sv
`timescale 1ns/1ps
`default_nettype none

module memReader import tsRecPkg::*; (
	input  logic       SYS_CLOCK,             // System clock.
	input  logic       SYS_RESET,             // Asynchronous reset, active high.
	input  tsMode_t    mode,                  // Current recorder mode.
	input  fifoCount_t fifoCount,             // Replay FIFO occupancy.
	input  logic       pushReady,             // Replay FIFO has room.
	output tsWord_t    word,                  // Returned sample.
	output logic       pushValid,             // Push request.
	output logic       readsDone,             // Memory side finished.
	memReadIf.reader   rd                     // Memory read channel.
);

	memAddr_t   issueAddr;                     // Next address, also reads issued.
	memAddr_t   returned;                      // Words returned so far.
	fifoCount_t outstanding;                   // Reads in flight.
	logic       roomLeft;
	logic       accept;

	//////////////////////////////////////////////////
	// Read issue under FIFO credit.

	assign roomLeft  = (outstanding + fifoCount) < fifoCount_t'(fifoDepth); // Space for one more.
	assign rd.read   = (mode == modeReplay) && roomLeft && pushReady
		&& (issueAddr < memAddr_t'(recWords));
	assign rd.address = issueAddr;
	assign accept    = rd.read && !rd.waitRequest;

	//////////////////////////////////////////////////
	// Returned data.

	assign word      = tsWord_t'(rd.readData[memDataW-1:wordPadW]); // Top ten bits.
	assign pushValid = rd.readDataValid && (mode == modeReplay);     // Discarded when stopping.
	assign readsDone = (outstanding == '0)
		&& ((mode == modeStopping) || (returned == memAddr_t'(recWords)));

	always_ff @(posedge SYS_CLOCK or posedge SYS_RESET) begin
		if (SYS_RESET) begin
			issueAddr   <= '0;
			returned    <= '0;
			outstanding <= '0;
		end else begin
			if (mode == modePass) begin
				issueAddr <= '0;                   // Each replay starts at zero.
				returned  <= '0;
			end else begin
				if (accept) issueAddr <= issueAddr + 1'b1;
				if (rd.readDataValid) returned <= returned + 1'b1;
			end
			// Track in flight reads in every mode.
			outstanding <= outstanding + fifoCount_t'(accept) - fifoCount_t'(rd.readDataValid);
		end
	end

endmodule

`default_nettype wire

//--- hdl/tsRecorderTop.sv
`timescale 1ns/1ps
`default_nettype none

module tsRecorderTop import tsRecPkg::*; (
	input  logic       SYS_CLOCK,             // System clock.
	input  logic       SYS_RESET,             // Asynchronous reset, active high.
	input  logic       rec,                   // Record pulse.
	input  logic       play,                  // Replay pulse.
	input  logic       pass,                  // Stop pulse.
	input  logic       tsValidIn,             // Stream valid in.
	input  logic       tsSyncIn,              // Stream sync in.
	input  logic [7:0] tsDataIn,              // Stream byte in.
	input  logic       memWrWaitRequest,      // Write stall.
	input  logic       memRdWaitRequest,      // Read stall.
	input  logic       memRdDataValid,        // Read data strobe.
	input  memData_t   memRdData,             // Read data.
	output logic       tsValidOut,            // Stream valid out.
	output logic       tsSyncOut,             // Stream sync out.
	output logic [7:0] tsDataOut,             // Stream byte out.
	output memAddr_t   memWrAddress,          // Write address.
	output logic       memWrWrite,            // Write request.
	output memData_t   memWrData,             // Write data.
	output memAddr_t   memRdAddress,          // Read address.
	output logic       memRdRead,             // Read request.
	output tsMode_t    mode,                  // Current mode.
	output logic       recOverflow            // Sticky lost word flag.
);

	tsWord_t    recordWord;                    // Port stage to record FIFO.
	logic       recordValid;
	logic       recordReady;
	tsWord_t    writerWord;                    // Record FIFO to writer.
	logic       writerValid;
	logic       writerReady;
	tsWord_t    readerWord;                    // Reader to replay FIFO.
	logic       readerValid;
	logic       readerReady;
	fifoCount_t replayCount;
	tsWord_t    replayWord;                    // Replay FIFO to port stage.
	logic       replayValid;
	logic       replayReady;
	logic       recordDone;
	logic       readsDone;

	memWriteIf wrBus ();
	memReadIf  rdBus ();

	//////////////////////////////////////////////////
	// Memory channels to plain ports.

	assign memWrAddress        = wrBus.address;
	assign memWrWrite          = wrBus.write;
	assign memWrData           = wrBus.writeData;
	assign wrBus.waitRequest   = memWrWaitRequest;
	assign memRdAddress        = rdBus.address;
	assign memRdRead           = rdBus.read;
	assign rdBus.waitRequest   = memRdWaitRequest;
	assign rdBus.readDataValid = memRdDataValid;
	assign rdBus.readData      = memRdData;

	//////////////////////////////////////////////////
	// Control and port stage.

	tsModeControl modeControl (
		.SYS_CLOCK, .SYS_RESET, .rec, .play, .pass,
		.recordDone, .readsDone,
		.replayPending (replayValid),          // Replay ends once this empties.
		.mode
	);

	tsPortStage portStage (
		.SYS_CLOCK, .SYS_RESET, .mode, .tsValidIn, .tsSyncIn, .tsDataIn,
		.recordReady, .replayWord, .replayValid, .rec,
		.tsValidOut, .tsSyncOut, .tsDataOut,
		.recordWord, .recordValid, .replayReady, .recOverflow
	);

	//////////////////////////////////////////////////
	// Record path.

	tsStreamFifo recordFifo (
		.SYS_CLOCK, .SYS_RESET, .mode,
		.inWord (recordWord), .inValid (recordValid), .outReady (writerReady),
		.inReady (recordReady), .outWord (writerWord), .outValid (writerValid),
		.count ()
	);

	memWriter writer (
		.SYS_CLOCK, .SYS_RESET, .mode,
		.word (writerWord), .valid (writerValid), .ready (writerReady),
		.recordDone, .wr (wrBus)
	);

	//////////////////////////////////////////////////
	// Replay path.

	memReader reader (
		.SYS_CLOCK, .SYS_RESET, .mode,
		.fifoCount (replayCount), .pushReady (readerReady),
		.word (readerWord), .pushValid (readerValid), .readsDone, .rd (rdBus)
	);

	tsStreamFifo replayFifo (
		.SYS_CLOCK, .SYS_RESET, .mode,
		.inWord (readerWord), .inValid (readerValid), .outReady (replayReady),
		.inReady (readerReady), .outWord (replayWord), .outValid (replayValid),
		.count (replayCount)
	);

endmodule

`default_nettype wire

//--- tb/tsRecorderTb.sv
`timescale 1ns/1ps
`default_nettype none

module tsRecorderTb import tsRecPkg::*; ();

	localparam logic [31:0] seed = 32'hc8338656; // Stimulus and memory seed.
	localparam int passWords  = 40;            // Words per passthrough run.
	localparam int stopAfter  = 16;            // Replay words before the stop pulse.
	localparam int stimCycles = 2 * passWords + 4 * recWords + 2 * fifoDepth + 40;

	logic       SYS_CLOCK = 1'b0;
	logic       SYS_RESET = 1'b1;
	logic       rec = 1'b0;
	logic       play = 1'b0;
	logic       pass = 1'b0;
	logic       tsValidIn = 1'b0;
	logic       tsSyncIn = 1'b0;
	logic [7:0] tsDataIn = '0;
	logic       memWrWaitRequest = 1'b0;
	logic       memRdWaitRequest = 1'b0;
	logic       memRdDataValid = 1'b0;
	memData_t   memRdData = '0;
	logic       tsValidOut, tsSyncOut, memWrWrite, memRdRead, recOverflow;
	logic [7:0] tsDataOut;
	memAddr_t   memWrAddress, memRdAddress;
	memData_t   memWrData;
	tsMode_t    mode;

	logic [31:0] rngState = seed;              // Stimulus generator.
	logic [31:0] memRng = seed;                // Memory timing generator.
	logic        rdRandom = 1'b0;              // Random read stalls on.
	memData_t    memory [2**memAddrW];
	memAddr_t    rdAddr [$];                   // Accepted reads in request order.
	int          rdDue [$];                    // Cycle each read returns.
	int          cycleCount = 0;
	int          lastDue = 0;
	tsWord_t     recorded [$];                 // Words fed during record.
	tsWord_t     replayed [$];                 // Valid words seen in replay.
	logic        sawStopping;
	string       testName;
	int          errorCount = 0;
	int          testStartErrors = 0;
	int          testsPassed = 0;
	int          testsFailed = 0;

	tsRecorderTop i_dut (.*);

	always #2 SYS_CLOCK = ~SYS_CLOCK;          // 4 ns period.

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	//////////////////////////////////////////////////
	// Memory model.

	always @(posedge SYS_CLOCK) begin : memoryModel
		int due;
		cycleCount++;
		memRng = xorshift32(memRng);
		memRdWaitRequest <= rdRandom && memRng[0];
		if (memWrWrite && !memWrWaitRequest) begin
			memory[memWrAddress] <= memWrData;    // Write accepted.
		end
		if (memRdRead && !memRdWaitRequest) begin
			due = cycleCount + 1 + int'(memRng[2:1]); // Latency 1 to 4.
			if (due <= lastDue) due = lastDue + 1; // Keeps returns in order.
			lastDue = due;
			rdAddr.push_back(memRdAddress);
			rdDue.push_back(due);
		end
		if (rdDue.size() > 0 && rdDue[0] <= cycleCount) begin
			memRdDataValid <= 1'b1;
			memRdData      <= memory[rdAddr.pop_front()];
			void'(rdDue.pop_front());
		end else begin
			memRdDataValid <= 1'b0;
			memRdData      <= '0;
		end
	end

	//////////////////////////////////////////////////
	// Checks and reporting.

	task automatic startTest(input string name);
		testName        = name;
		testStartErrors = errorCount;
	endtask

	task automatic finishTest();
		if (errorCount == testStartErrors) begin
			testsPassed++;
			$display("PASS %s", testName);
		end else begin
			testsFailed++;
			$display("FAIL %s with %0d errors", testName, errorCount - testStartErrors);
		end
	endtask

	task automatic reportError(input string msg);
		errorCount++;
		$display("error in %s: %s", testName, msg);
	endtask

	task automatic checkWord(input tsWord_t expected, input tsWord_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s word: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	task automatic checkMode(input tsMode_t expected, input tsMode_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s mode: expected %s, actual %s", testName,
				expected.name(), actual.name());
		end
	endtask

	task automatic checkBit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s %s: expected %b, actual %b", testName, what, expected, actual);
		end
	endtask

	task automatic checkData(input memData_t expected, input memData_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s memory: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers.

	task automatic driveWord(input tsWord_t w);
		tsValidIn <= w.valid;
		tsSyncIn  <= w.sync;
		tsDataIn  <= w.data;
	endtask

	task automatic pulseControl(input logic r, input logic p);
		@(posedge SYS_CLOCK);
		rec  <= r;
		play <= p;
		@(posedge SYS_CLOCK);
		rec  <= 1'b0;
		play <= 1'b0;
	endtask

	task automatic waitMode(input tsMode_t target, input int limit);
		int n;
		n = 0;
		while (mode != target && n < limit) begin
			@(posedge SYS_CLOCK);
			n++;
		end
		if (mode != target) reportError($sformatf("mode never reached %s", target.name()));
	endtask

	task automatic runPassthrough(input int count);
		tsWord_t sent [$];
		tsWord_t w;
		for (int i = 0; i < count + 3; i++) begin
			@(posedge SYS_CLOCK);
			// Word driven three edges back appears after two cycles of latency.
			if (i >= 3) checkWord(sent[i - 3], tsWord_t'({tsValidOut, tsSyncOut, tsDataOut}));
			checkMode(modePass, mode);
			rngState = xorshift32(rngState);
			w = (i < count) ? tsWord_t'(rngState[9:0]) : '0;
			sent.push_back(w);
			driveWord(w);
		end
	endtask

	// Collects valid output words until passthrough, stopping early if asked.
	task automatic collectReplay(input int stopAt);
		int   n;
		logic stopped;
		replayed.delete();
		sawStopping = 1'b0;
		stopped     = 1'b0;
		n           = 0;
		while (mode != modePass && n < recWords * 20) begin
			@(posedge SYS_CLOCK);
			n++;
			if (tsValidOut) replayed.push_back(tsWord_t'({tsValidOut, tsSyncOut, tsDataOut}));
			if (mode == modeStopping) sawStopping = 1'b1;
			if (!stopped && replayed.size() == stopAt) begin
				pass    <= 1'b1;                  // Abort partway.
				stopped = 1'b1;
			end else begin
				pass <= 1'b0;
			end
		end
		pass <= 1'b0;
		if (mode != modePass) reportError("replay never returned to passthrough");
	endtask

	//////////////////////////////////////////////////
	// Directed tests.

	task automatic testReset();
		startTest("reset");
		@(posedge SYS_CLOCK);
		checkMode(modePass, mode);
		checkBit("memWrWrite", 1'b0, memWrWrite);
		checkBit("memRdRead", 1'b0, memRdRead);
		checkBit("tsValidOut", 1'b0, tsValidOut);
		checkBit("recOverflow", 1'b0, recOverflow);
		finishTest();
	endtask

	task automatic testPassthrough();
		startTest("passthrough");
		runPassthrough(passWords);
		finishTest();
	endtask

	task automatic testRecord();
		tsWord_t  w;
		memData_t expWord;
		startTest("record");
		recorded.delete();
		pulseControl(1'b1, 1'b0);
		waitMode(modeRecord, 10);
		while (recorded.size() < recWords) begin
			@(posedge SYS_CLOCK);
			rngState = xorshift32(rngState);
			w = '{valid: 1'b1, sync: rngState[8], data: rngState[7:0]};
			driveWord(w);
			recorded.push_back(w);
			repeat (1 + int'(rngState[10:9])) begin
				@(posedge SYS_CLOCK);
				driveWord('0);                    // Idle gap.
			end
		end
		waitMode(modePass, recWords * 8);
		for (int i = 0; i < recWords; i++) begin
			expWord        = '0;
			expWord[31:22] = recorded[i];         // Sample in the top ten bits.
			checkData(expWord, memory[memAddr_t'(i)]);
		end
		checkBit("recOverflow", 1'b0, recOverflow);
		finishTest();
	endtask

	task automatic testReplay();
		startTest("replay");
		rdRandom <= 1'b1;
		pulseControl(1'b0, 1'b1);
		waitMode(modeReplay, 10);
		collectReplay(-1);
		if (replayed.size() != recWords) begin
			reportError($sformatf("replay gave %0d words, not %0d", replayed.size(), recWords));
		end
		for (int i = 0; i < replayed.size() && i < recWords; i++) begin
			checkWord(recorded[i], replayed[i]);
		end
		checkMode(modePass, mode);
		finishTest();
	endtask

	task automatic testStop();
		startTest("stop");
		pulseControl(1'b0, 1'b1);
		waitMode(modeReplay, 10);
		collectReplay(stopAfter);
		checkBit("sawStopping", 1'b1, sawStopping);
		if (replayed.size() >= recWords) reportError("replay was not cut short");
		for (int i = 0; i < replayed.size() && i < recWords; i++) begin
			checkWord(recorded[i], replayed[i]); // Prefix of the recording.
		end
		runPassthrough(passWords);
		finishTest();
	endtask

	task automatic testOverflow();
		startTest("overflow");
		@(posedge SYS_CLOCK);
		memWrWaitRequest <= 1'b1;                // Writer stalls for good.
		pulseControl(1'b1, 1'b0);
		waitMode(modeRecord, 10);
		repeat (fifoDepth + 6) begin
			@(posedge SYS_CLOCK);
			rngState = xorshift32(rngState);
			driveWord('{valid: 1'b1, sync: rngState[8], data: rngState[7:0]});
		end
		repeat (3) begin
			@(posedge SYS_CLOCK);
			driveWord('0);
		end
		@(posedge SYS_CLOCK);
		checkBit("recOverflow", 1'b1, recOverflow);
		pulseControl(1'b1, 1'b0);                // Next rec pulse clears it.
		repeat (2) @(posedge SYS_CLOCK);
		checkBit("recOverflow", 1'b0, recOverflow);
		finishTest();
	endtask

	//////////////////////////////////////////////////
	// Sequence and watchdog.

	initial begin
		repeat (10) @(posedge SYS_CLOCK);
		SYS_RESET <= 1'b0;
		testReset();
		testPassthrough();
		testRecord();
		testReplay();
		testStop();
		testOverflow();
		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		repeat (stimCycles * 20) @(posedge SYS_CLOCK);
		$display("error: watchdog expired after %0d cycles", stimCycles * 20);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
hdl/tsRecPkg.sv
hdl/memWriteIf.sv
hdl/memReadIf.sv
hdl/tsStreamFifo.sv
hdl/tsModeControl.sv
hdl/tsPortStage.sv
hdl/memWriter.sv
hdl/memReader.sv
hdl/tsRecorderTop.sv
tb/tsRecorderTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the simulation, judge the run from its log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module tsRecorderTb -o tsRecorderSim \
	> build.log 2>&1 || { cat build.log; echo "Test failed"; exit 1; }
./obj_dir/tsRecorderSim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
